// ==== design/videoPkg.sv ====
package videoPkg;

	// CRTC timing registers, counts are in characters or character rows
	typedef struct packed {
		logic [7:0]  hTotal;
		logic [7:0]  hDisplayed;
		logic [7:0]  hSyncPos;
		logic [3:0]  hSyncWidth;
		logic [6:0]  vTotal;
		logic [6:0]  vDisplayed;
		logic [6:0]  vSyncPos;
		logic [2:0]  maxScanLine;
		logic [11:0] startAddr;
	} crtcRegsT;

	typedef enum logic [0:0] {bpp1, bpp2} pixelModeT;

	typedef struct packed {
		pixelModeT       mode;
		logic [3:0][2:0] palette; // RGB per entry
	} ulaRegsT;

	// Screen-size latch bits, amount taken off on wraparound
	typedef enum logic [1:0] {wrapNone, wrap1K, wrap2K, wrap3K} wrapSizeT;

	typedef struct packed {
		logic        valid;
		logic [11:0] addr;
		logic [7:0]  data;
	} memWriteT;

	typedef struct packed {
		logic [11:0] charAddr;
		logic [2:0]  row;
		logic        dispEn;
		logic        hSync;
		logic        vSync;
		logic [3:0]  phase; // Pixel within the character
	} fetchReqT;

	typedef struct packed {
		logic [2:0] rgb;
		logic       hSync;
		logic       vSync;
	} pixelOutT;

	// Register port address map
	typedef enum logic [15:0] {
		crtcBase = 16'h0000,
		ulaCtrl  = 16'h0040,
		palette0 = 16'h0044,
		palette1 = 16'h0048,
		palette2 = 16'h004C,
		palette3 = 16'h0050,
		latch    = 16'h0080,
		memBase  = 16'h1000
	} regAddrT;

endpackage

// ==== design/videoRegs.sv ====
`timescale 1ns/1ns

module videoRegs (
	input  logic               PIXELCLK,
	input  logic               arstN,
	input  logic [15:0]        awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  logic [31:0]        wdata,
	input  logic               wvalid,
	output logic               wready,
	output logic [1:0]         bresp,
	output logic               bvalid,
	input  logic               bready,
	input  logic [15:0]        araddr,
	input  logic               arvalid,
	output logic               arready,
	output logic [31:0]        rdata,
	output logic [1:0]         rresp,
	output logic               rvalid,
	input  logic               rready,
	output videoPkg::crtcRegsT crtc,
	output videoPkg::ulaRegsT  ula,
	output videoPkg::wrapSizeT wrapSize,
	output videoPkg::memWriteT memWrite
);

	typedef enum logic {idle, respond} busStateT;

	busStateT wrState;
	busStateT rdState;
	logic wrAccept;
	logic rdAccept;
	logic wrCrtc;
	logic wrMem;
	logic rdCrtc;
	logic [31:0] rdValue;

	// One transaction in flight per direction
	assign awready = (wrState == idle);
	assign wready = (wrState == idle);
	assign arready = (rdState == idle);
	assign bvalid = (wrState == respond);
	assign rvalid = (rdState == respond);
	assign bresp = 2'b00; // OKAY
	assign rresp = 2'b00;

	assign wrAccept = awvalid && wvalid && (wrState == idle);
	assign rdAccept = arvalid && (rdState == idle);

	// CRTC registers sit on a 4-byte stride from crtcBase
	assign wrCrtc = ((awaddr & 16'hFFC0) == videoPkg::crtcBase);
	assign rdCrtc = ((araddr & 16'hFFC0) == videoPkg::crtcBase);
	assign wrMem = ((awaddr & 16'hF000) == videoPkg::memBase);

	// Framestore write strobe, live on the accept cycle only
	always_comb begin
		memWrite.valid = wrAccept && wrMem;
		memWrite.addr = awaddr[11:0];
		memWrite.data = wdata[7:0];
	end

	always_ff @(posedge PIXELCLK or negedge arstN) begin
		if (!arstN) begin
			crtc <= '0;
			ula <= '0;
			wrapSize <= videoPkg::wrapNone;
		end else if (wrAccept) begin
			if (wrCrtc) begin
				case (awaddr[5:2])
					4'd0: crtc.hTotal <= wdata[7:0];
					4'd1: crtc.hDisplayed <= wdata[7:0];
					4'd2: crtc.hSyncPos <= wdata[7:0];
					4'd3: crtc.hSyncWidth <= wdata[3:0];
					4'd4: crtc.vTotal <= wdata[6:0];
					4'd5: crtc.vDisplayed <= wdata[6:0];
					4'd6: crtc.vSyncPos <= wdata[6:0];
					4'd7: crtc.maxScanLine <= wdata[2:0];
					4'd8: crtc.startAddr <= wdata[11:0];
					default: ;
				endcase
			end
			case (awaddr)
				videoPkg::ulaCtrl: ula.mode <= videoPkg::pixelModeT'(wdata[0]);
				videoPkg::palette0: ula.palette[0] <= wdata[2:0];
				videoPkg::palette1: ula.palette[1] <= wdata[2:0];
				videoPkg::palette2: ula.palette[2] <= wdata[2:0];
				videoPkg::palette3: ula.palette[3] <= wdata[2:0];
				videoPkg::latch: wrapSize <= videoPkg::wrapSizeT'(wdata[1:0]);
				default: ;
			endcase
		end
	end

	// Read mux, framestore reads fall through to zero
	always_comb begin
		rdValue = '0;
		if (rdCrtc) begin
			case (araddr[5:2])
				4'd0: rdValue = 32'(crtc.hTotal);
				4'd1: rdValue = 32'(crtc.hDisplayed);
				4'd2: rdValue = 32'(crtc.hSyncPos);
				4'd3: rdValue = 32'(crtc.hSyncWidth);
				4'd4: rdValue = 32'(crtc.vTotal);
				4'd5: rdValue = 32'(crtc.vDisplayed);
				4'd6: rdValue = 32'(crtc.vSyncPos);
				4'd7: rdValue = 32'(crtc.maxScanLine);
				4'd8: rdValue = 32'(crtc.startAddr);
				default: ;
			endcase
		end
		case (araddr)
			videoPkg::ulaCtrl: rdValue = 32'(ula.mode);
			videoPkg::palette0: rdValue = 32'(ula.palette[0]);
			videoPkg::palette1: rdValue = 32'(ula.palette[1]);
			videoPkg::palette2: rdValue = 32'(ula.palette[2]);
			videoPkg::palette3: rdValue = 32'(ula.palette[3]);
			videoPkg::latch: rdValue = 32'(wrapSize);
			default: ;
		endcase
	end

	always_ff @(posedge PIXELCLK) begin
		if (rdAccept) begin
			rdata <= rdValue;
		end
	end

	always_ff @(posedge PIXELCLK or negedge arstN) begin
		if (!arstN) begin
			wrState <= idle;
			rdState <= idle;
		end else begin
			case (wrState)
				idle: if (wrAccept) wrState <= respond;
				respond: if (bready) wrState <= idle; // Held until the master takes it
				default: wrState <= idle;
			endcase
			case (rdState)
				idle: if (rdAccept) rdState <= respond;
				respond: if (rready) rdState <= idle;
				default: rdState <= idle;
			endcase
		end
	end

endmodule

// ==== design/crtcTiming.sv ====
`timescale 1ns/1ns

module crtcTiming (
	input  logic               PIXELCLK,
	input  logic               arstN,
	input  videoPkg::crtcRegsT crtc,
	output videoPkg::fetchReqT fetch
);

	logic [2:0] phase;
	logic [7:0] col;
	logic [2:0] scan;
	logic [6:0] charRow;
	logic [11:0] rowStart; // Address of column 0 on this row
	logic endChar;
	logic endLine;
	logic endRow;
	logic endFrame;
	logic [8:0] hSyncEnd;
	logic timingOn;
	logic inHSync;

	// Compares use >= so a shrunk register still ends the count
	assign endChar = (phase == 3'd7);
	assign endLine = endChar && (col >= crtc.hTotal);
	assign endRow = endLine && (scan >= crtc.maxScanLine);
	assign endFrame = endRow && (charRow >= crtc.vTotal);

	// Syncs stay quiet until a line length is programmed
	assign timingOn = (crtc.hTotal != 8'd0);

	assign hSyncEnd = 9'(crtc.hSyncPos) + 9'(crtc.hSyncWidth);
	assign inHSync = (9'(col) >= 9'(crtc.hSyncPos)) && (9'(col) < hSyncEnd);

	always_ff @(posedge PIXELCLK or negedge arstN) begin
		if (!arstN) begin
			phase <= '0;
			col <= '0;
			scan <= '0;
			charRow <= '0;
			rowStart <= '0;
		end else begin
			phase <= phase + 3'd1; // Eight pixels per character
			if (endChar) begin
				col <= endLine ? 8'd0 : col + 8'd1;
			end
			if (endLine) begin
				scan <= endRow ? 3'd0 : scan + 3'd1;
			end
			if (endRow) begin
				if (endFrame) begin
					charRow <= '0;
					rowStart <= crtc.startAddr; // New frame origin
				end else begin
					charRow <= charRow + 7'd1;
					rowStart <= rowStart + 12'(crtc.hDisplayed);
				end
			end
		end
	end

	always_ff @(posedge PIXELCLK or negedge arstN) begin
		if (!arstN) begin
			fetch <= '0;
		end else begin
			fetch.charAddr <= rowStart + 12'(col);
			fetch.row <= scan;
			fetch.dispEn <= (col < crtc.hDisplayed) && (charRow < crtc.vDisplayed);
			fetch.hSync <= timingOn && inHSync;
			fetch.vSync <= timingOn && (charRow == crtc.vSyncPos); // Whole character row
			fetch.phase <= {1'b0, phase};
		end
	end

endmodule

// ==== design/screenMemory.sv ====
`timescale 1ns/1ns

module screenMemory #(
	parameter int memBytes = 4096,
	parameter int addrBits = 12
) (
	input  logic               PIXELCLK,
	input  logic               arstN,
	input  videoPkg::wrapSizeT wrapSize,
	input  videoPkg::memWriteT memWrite,
	input  videoPkg::fetchReqT fetchIn,
	output videoPkg::fetchReqT fetchOut,
	output logic [7:0]         pixelByte
);

	logic [7:0] ram [memBytes];
	logic [15:0] linearAddr;
	logic [15:0] wrapBytes;
	logic [15:0] correctedAddr;
	logic [addrBits-1:0] rdAddr;
	logic [addrBits-1:0] wrAddr;

	// Eight bytes per character, one per scanline
	assign linearAddr = {1'b0, fetchIn.charAddr, fetchIn.row};

	always_comb begin
		case (wrapSize)
			videoPkg::wrap1K: wrapBytes = 16'd1024;
			videoPkg::wrap2K: wrapBytes = 16'd2048;
			videoPkg::wrap3K: wrapBytes = 16'd3072;
			default: wrapBytes = 16'd0;
		endcase
	end

	// Pull addresses past the top back into the screen area
	assign correctedAddr = (linearAddr >= 16'(memBytes)) ? linearAddr - wrapBytes
		: linearAddr;

	// Dropping the high bits gives the modulo wrap
	assign rdAddr = correctedAddr[addrBits-1:0];
	assign wrAddr = addrBits'(memWrite.addr);

	always_ff @(posedge PIXELCLK) begin
		if (memWrite.valid) begin
			ram[wrAddr] <= memWrite.data;
		end
		pixelByte <= ram[rdAddr]; // Video read every cycle
	end

	// Context follows the byte through the read cycle
	always_ff @(posedge PIXELCLK or negedge arstN) begin
		if (!arstN) begin
			fetchOut <= '0;
		end else begin
			fetchOut <= fetchIn;
		end
	end

endmodule

// ==== design/pixelSerializer.sv ====
`timescale 1ns/1ns

module pixelSerializer (
	input  logic               PIXELCLK,
	input  logic               arstN,
	input  videoPkg::ulaRegsT  ula,
	input  videoPkg::fetchReqT fetch,
	input  logic [7:0]         pixelByte,
	output videoPkg::pixelOutT pixel
);

	logic [2:0] pos;
	logic [2:0] bitIdx;
	logic [2:0] hiIdx;
	logic [2:0] loIdx;
	logic [1:0] entry;
	logic [2:0] colour;

	assign pos = fetch.phase[2:0];

	// Leftmost pixel comes from bit 7
	assign bitIdx = 3'd7 - pos;

	// Pairs step every other phase so each pixel lasts two cycles
	assign hiIdx = 3'd7 - {pos[2:1], 1'b0};
	assign loIdx = hiIdx - 3'd1;

	always_comb begin
		if (ula.mode == videoPkg::bpp2) begin
			entry = {pixelByte[hiIdx], pixelByte[loIdx]};
		end else begin
			entry = {1'b0, pixelByte[bitIdx]}; // Entries 0 and 1 only
		end
	end

	// Outside the display area the beam is black
	assign colour = fetch.dispEn ? ula.palette[entry] : 3'b000;

	always_ff @(posedge PIXELCLK or negedge arstN) begin
		if (!arstN) begin
			pixel <= '0;
		end else begin
			pixel.rgb <= colour;
			pixel.hSync <= fetch.hSync; // Same stage as the colour
			pixel.vSync <= fetch.vSync;
		end
	end

endmodule

// ==== design/videoTop.sv ====
`timescale 1ns/1ns

module videoTop #(
	parameter int memBytes = 4096,
	parameter int addrBits = 12
) (
	input  logic        PIXELCLK,
	input  logic        arstN,
	input  logic [15:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [15:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic [2:0]  rgb,
	output logic        hSync,
	output logic        vSync
);

	videoPkg::crtcRegsT crtc;
	videoPkg::ulaRegsT ula;
	videoPkg::wrapSizeT wrapSize;
	videoPkg::memWriteT memWrite;
	videoPkg::fetchReqT fetchTiming; // From the counters
	videoPkg::fetchReqT fetchMem;    // Paired with pixelByte
	videoPkg::pixelOutT pixel;
	logic [7:0] pixelByte;

	videoRegs videoRegs_inst (
		.PIXELCLK(PIXELCLK),
		.arstN(arstN),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.crtc(crtc),
		.ula(ula),
		.wrapSize(wrapSize),
		.memWrite(memWrite)
	);

	crtcTiming crtcTiming_inst (
		.PIXELCLK(PIXELCLK),
		.arstN(arstN),
		.crtc(crtc),
		.fetch(fetchTiming)
	);

	screenMemory #(
		.memBytes(memBytes),
		.addrBits(addrBits)
	) screenMemory_inst (
		.PIXELCLK(PIXELCLK),
		.arstN(arstN),
		.wrapSize(wrapSize),
		.memWrite(memWrite),
		.fetchIn(fetchTiming),
		.fetchOut(fetchMem),
		.pixelByte(pixelByte)
	);

	pixelSerializer pixelSerializer_inst (
		.PIXELCLK(PIXELCLK),
		.arstN(arstN),
		.ula(ula),
		.fetch(fetchMem),
		.pixelByte(pixelByte),
		.pixel(pixel)
	);

	assign rgb = pixel.rgb;
	assign hSync = pixel.hSync;
	assign vSync = pixel.vSync;

endmodule

// ==== tb/videoClock.sv ====
`timescale 1ns/1ns

module videoClock (
	output logic PIXELCLK,
	output logic arstN
);

	// 8 ns period
	initial begin
		PIXELCLK = 1'b0;
		forever #4 PIXELCLK = ~PIXELCLK;
	end

	initial begin
		arstN = 1'b0;
		repeat (3) @(posedge PIXELCLK);
		#1 arstN = 1'b1; // Released just after the third edge
	end

endmodule

// ==== tb/videoChecker.sv ====
`timescale 1ns/1ns

module videoChecker (
	input  logic        PIXELCLK,
	input  logic        arstN,
	input  logic [2:0]  rgb,
	input  logic        hSync,
	input  logic        vSync,
	input  logic        awready,
	input  logic        wready,
	input  logic [1:0]  bresp,
	input  logic        bvalid,
	input  logic        bready,
	input  logic        arready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	input  logic        rvalid,
	input  logic        rready,
	input  logic        quiet,
	input  logic        pixLoad,
	input  int          pixLine,
	input  int          pixCol,
	input  logic [2:0]  pixRgb,
	input  logic        rdLoad,
	input  logic [31:0] rdExp,
	input  logic        syncOn,
	input  int          hPeriod,
	input  int          vPeriod,
	output logic        pixBusy,
	output int          errors
);

	int x; // Column within the line counted from the vSync edge
	int y;
	int hCount;
	int vCount;
	int wantLine;
	int wantCol;
	logic locked;
	logic hPrev;
	logic vPrev;
	logic hSeen;
	logic vSeen;
	logic pixArmed;
	logic rdArmed;
	logic bHeld;
	logic [2:0] wantRgb;
	logic [31:0] wantData;

	assign pixBusy = pixArmed;

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, want);
	endtask

	task automatic reportFailure(input string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	always @(posedge PIXELCLK or negedge arstN) begin
		if (!arstN) begin
			errors = 0;
			x = 0;
			y = 0;
			hCount = 0;
			vCount = 0;
			wantLine = 0;
			wantCol = 0;
			locked = 1'b0;
			hPrev = 1'b0;
			vPrev = 1'b0;
			hSeen = 1'b0;
			vSeen = 1'b0;
			pixArmed = 1'b0;
			rdArmed = 1'b0;
			bHeld = 1'b0;
			wantRgb = 3'b000;
			wantData = '0;
		end else begin
			if (quiet && (rgb != 3'b000 || hSync || vSync)) begin
				reportMismatch("rgb hSync vSync", 32'({rgb, hSync, vSync}), 32'h0);
			end
			// Beam position follows the aligned vSync rise
			if (vSync && !vPrev) begin
				x = 0;
				y = 0;
				locked = 1'b1;
			end else if (locked && hPeriod > 0) begin
				if (x >= hPeriod - 1) begin
					x = 0;
					y++;
				end else begin
					x++;
				end
			end
			if (pixArmed && locked && y == wantLine && x == wantCol) begin
				if (rgb != wantRgb) begin
					reportMismatch($sformatf("rgb at line %0d col %0d", y, x),
						32'(rgb), 32'(wantRgb));
				end
				pixArmed = 1'b0;
			end
			if (pixLoad) begin
				wantLine = pixLine;
				wantCol = pixCol;
				wantRgb = pixRgb;
				pixArmed = 1'b1;
			end
			if (rdArmed && rvalid && rready) begin
				if (rdata != wantData) begin
					reportMismatch("rdata", rdata, wantData);
				end
				rdArmed = 1'b0;
			end
			if (rdLoad) begin
				wantData = rdExp;
				rdArmed = 1'b1;
			end
			// A pending response holds and blocks the next request
			if (bHeld && !bvalid) begin
				reportFailure("write response dropped while bready was low");
			end
			if (bvalid && (awready || wready)) begin
				reportFailure("write ready high while a response was pending");
			end
			if (bvalid && bready && bresp != 2'b00) begin
				reportMismatch("bresp", 32'(bresp), 32'h0);
			end
			if (rvalid && arready) begin
				reportFailure("read ready high while a response was pending");
			end
			if (rvalid && rready && rresp != 2'b00) begin
				reportMismatch("rresp", 32'(rresp), 32'h0);
			end
			bHeld = bvalid && !bready;
			if (!syncOn) begin
				hSeen = 1'b0;
				vSeen = 1'b0;
			end
			// Edge spacing counts cycles between rising edges
			if (hSync && !hPrev) begin
				if (hSeen && hCount != hPeriod) begin
					reportMismatch("hSync period", 32'(hCount), 32'(hPeriod));
				end
				hSeen = syncOn;
				hCount = 1;
			end else begin
				hCount++;
			end
			if (vSync && !vPrev) begin
				if (vSeen && vCount != vPeriod) begin
					reportMismatch("vSync period", 32'(vCount), 32'(vPeriod));
				end
				vSeen = syncOn;
				vCount = 1;
			end else begin
				vCount++;
			end
			hPrev = hSync;
			vPrev = vSync;
		end
	end

endmodule

// ==== tb/videoTb.sv ====
`timescale 1ns/1ns

module videoTb;

	logic PIXELCLK;
	logic arstN;
	logic [15:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [15:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [2:0] rgb;
	logic hSync;
	logic vSync;
	logic quiet;
	logic pixLoad;
	int pixLine;
	int pixCol;
	logic [2:0] pixRgb;
	logic rdLoad;
	logic [31:0] rdExp;
	logic syncOn;
	int hPeriod;
	int vPeriod;
	logic pixBusy;
	int checkErrors;

	videoClock videoClock_inst (.PIXELCLK(PIXELCLK), .arstN(arstN));

	videoTop videoTop_inst (
		.PIXELCLK(PIXELCLK), .arstN(arstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.rgb(rgb), .hSync(hSync), .vSync(vSync)
	);

	videoChecker videoChecker_inst (
		.PIXELCLK(PIXELCLK), .arstN(arstN), .rgb(rgb), .hSync(hSync), .vSync(vSync),
		.awready(awready), .wready(wready), .bresp(bresp), .bvalid(bvalid),
		.bready(bready), .arready(arready), .rdata(rdata), .rresp(rresp),
		.rvalid(rvalid), .rready(rready), .quiet(quiet),
		.pixLoad(pixLoad), .pixLine(pixLine), .pixCol(pixCol), .pixRgb(pixRgb),
		.rdLoad(rdLoad), .rdExp(rdExp), .syncOn(syncOn), .hPeriod(hPeriod),
		.vPeriod(vPeriod), .pixBusy(pixBusy), .errors(checkErrors)
	);

	task automatic nextCycle();
		@(posedge PIXELCLK);
		#1;
	endtask

	task automatic abortRun(input string msg);
		$display("Error: %s", msg);
		$display("Errors: checker %0d, fatal 1", checkErrors);
		$display("Test failed");
		$finish;
	endtask

	task automatic axiWrite(input logic [15:0] a, input logic [31:0] d, input int hold);
		int n;
		awaddr = a;
		wdata = d;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (hold == 0);
		quiet = 1'b0;
		n = 0;
		while (!(awready && wready)) begin
			if (n++ > 100) abortRun("write address never accepted");
			nextCycle();
		end
		nextCycle(); // Accepted on this edge
		awvalid = 1'b0;
		wvalid = 1'b0;
		repeat (hold) nextCycle(); // Response stays pending meanwhile
		bready = 1'b1;
		n = 0;
		while (!bvalid) begin
			if (n++ > 100) abortRun("write response never arrived");
			nextCycle();
		end
		nextCycle();
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [15:0] a, input logic [31:0] e);
		int n;
		araddr = a;
		arvalid = 1'b1;
		rready = 1'b1;
		rdExp = e;
		rdLoad = 1'b1;
		n = 0;
		while (!arready) begin
			if (n++ > 100) abortRun("read address never accepted");
			nextCycle();
		end
		nextCycle();
		arvalid = 1'b0;
		rdLoad = 1'b0;
		n = 0;
		while (!rvalid) begin
			if (n++ > 100) abortRun("read data never arrived");
			nextCycle();
		end
		nextCycle();
		rready = 1'b0;
	endtask

	task automatic waitFrames(input int frames);
		int seen;
		int n;
		logic prev;
		seen = 0;
		n = 0;
		prev = vSync;
		while (seen < frames) begin
			if (n++ > frames * 4000 + 4000) abortRun("frame sync never came");
			nextCycle();
			if (vSync && !prev) seen++;
			prev = vSync;
		end
	endtask

	task automatic checkPixel(input int line, input int col, input logic [2:0] c);
		int n;
		pixLine = line;
		pixCol = col;
		pixRgb = c;
		pixLoad = 1'b1;
		nextCycle();
		pixLoad = 1'b0;
		n = 0;
		while (pixBusy) begin
			if (n++ > 8000) abortRun("pixel position never reached");
			nextCycle();
		end
	endtask

	initial begin
		int fd;
		int n;
		string lineBuf;
		byte kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		quiet = 1'b1;
		pixLoad = 1'b0;
		pixLine = 0;
		pixCol = 0;
		pixRgb = 3'b000;
		rdLoad = 1'b0;
		rdExp = '0;
		syncOn = 1'b0;
		hPeriod = 0;
		vPeriod = 0;
		n = 0;
		while (!arstN) begin
			if (n++ > 20) abortRun("reset never released");
			nextCycle();
		end
		repeat (200) nextCycle(); // Outputs must stay quiet here
		fd = $fopen("tb/videoTests.txt", "r");
		if (fd == 0) abortRun("tests file could not be opened");
		while (!$feof(fd)) begin
			kind = 8'h00;
			if ($fgets(lineBuf, fd) != 0) begin
				n = $sscanf(lineBuf, "%c %h %h %h", kind, a, b, c);
			end
			if (kind == "W") axiWrite(a[15:0], b, int'(c));
			else if (kind == "R") axiRead(a[15:0], b);
			else if (kind == "P") checkPixel(int'(a), int'(b), c[2:0]);
			else if (kind == "F") waitFrames(int'(a));
			else if (kind == "H") begin
				hPeriod = int'(a);
				vPeriod = int'(b);
				syncOn = 1'b1;
			end
		end
		$fclose(fd);
		waitFrames(1);
		$display("Errors: checker %0d, fatal 0", checkErrors);
		if (checkErrors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tb/videoTests.txt ====
# W addr data breadyHold | R addr expect | P line col rgb | F frames
# H hSyncPeriod vSyncPeriod turns on edge spacing checks; every field is hex
R 0000 0
R 0044 0
R 1000 0
W 001C F9 0
R 001C 1
W 000C 12 0
R 000C 2
W 0018 84 0
R 0018 4
W 0044 F9 0
R 0044 1
W 0080 04 0
R 0080 0
W 0004 10 0
W 0008 11 0
W 0010 5 0
W 0014 4 0
W 0048 6 0
W 1000 A5 0
W 1009 0F 0
W 0000 13 0
F 2
H A0 780
P 4 0 6
P 4 1 1
P 4 5 6
P 5 8 1
P 5 C 6
P 4 82 0
P 0 0 0
W 0040 1 0
W 0048 2 0
W 004C 4 0
W 0050 7 0
W 1000 1B 0
F 1
P 4 1 1
P 4 2 2
P 4 5 4
P 4 7 7
W 0050 5 14
P 4 6 5
W 1FF8 55 0
W 1C00 F0 0
W 1800 0F 0
W 0020 1FC 0
W 0080 1 0
F 2
P 4 18 2
P 4 20 5
P 4 26 1
W 0080 2 0
F 1
P 4 20 1
P 4 26 5
F 1

// ==== all.f ====
design/videoPkg.sv
design/videoRegs.sv
design/crtcTiming.sv
design/screenMemory.sv
design/pixelSerializer.sv
design/videoTop.sv
tb/videoClock.sv
tb/videoChecker.sv
tb/videoTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the testbench with Verilator, then search the log for the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module videoTb -f all.f > build.log 2>&1 &&
	./obj_dir/VvideoTb > sim.log 2>&1 ||
	echo "build or simulation returned an error"
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
